/* logic/exu_macros.svh */
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath width of the execute unit
`define EXU_XLEN 64

// shift amount taken from the low bits of operand b
`define EXU_SHAMT_W 6

// iteration counter of the shift-add multiplier
// wide enough to hold one full pass over EXU_XLEN bits
`define EXU_MUL_CNT_W 7

`endif

/* logic/alu_pkg.sv */
package alu_pkg;

    // one code per alu operation
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_return_a,
        alu_return_b,
        // bitwise logic
        alu_xor,
        alu_or,
        alu_and,
        // shifts by b[5:0]
        alu_sll,
        alu_srl,
        alu_sra,
        // compares give 1 or 0
        alu_slt,
        alu_sltu,
        alu_eq,
        alu_ge,
        alu_geu,
        // iterative, stalls the stage
        alu_mul,
        // divide and remainder, riscv zero and overflow rules
        alu_div,
        alu_divu,
        alu_rem,
        alu_remu
    } alu_op_e;

endpackage

/* logic/exu_pkg.sv */
package exu_pkg;

    // operand a source
    typedef enum logic {
        src_pc,
        src_rs1
    } src_a_e;

    // operand b source
    typedef enum logic [1:0] {
        src_rs2,
        src_csr,
        src_imm
    } src_b_e;

    // shift-add multiplier control
    typedef enum logic [1:0] {
        mul_idle,
        mul_busy,
        mul_done
    } mul_state_e;

endpackage

/* logic/exu_stage_if.sv */
`include "exu_macros.svh"

interface exu_stage_if;

    logic                   valid;
    logic                   ready;
    alu_pkg::alu_op_e       op;
    logic [`EXU_XLEN-1:0]   a;
    logic [`EXU_XLEN-1:0]   b;
    // 32-bit operation, only sra looks at it
    logic                   word;

    modport source (
        output valid,
        output op,
        output a,
        output b,
        output word,
        input  ready
    );

    modport sink (
        input  valid,
        input  op,
        input  a,
        input  b,
        input  word,
        output ready
    );

endinterface

/* logic/operand_select.sv */
`include "exu_macros.svh"

module operand_select (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`EXU_XLEN-1:0]    pc,
    input  logic [`EXU_XLEN-1:0]    rs1,
    input  logic [`EXU_XLEN-1:0]    rs2,
    input  logic [`EXU_XLEN-1:0]    csr,
    input  logic [`EXU_XLEN-1:0]    imm,
    input  exu_pkg::src_a_e         src_a,
    input  exu_pkg::src_b_e         src_b,
    input  logic                    word,
    input  alu_pkg::alu_op_e        op,
    exu_stage_if.source             issue
);

    localparam int XLEN = `EXU_XLEN;

    logic [XLEN-1:0] a_sel;
    logic [XLEN-1:0] b_sel;
    logic            active;
    logic            accept;

    // rs1 narrowed to its low word when word is set
    assign a_sel = (src_a == exu_pkg::src_rs1) ?
                   (word ? {32'b0, rs1[31:0]} : rs1) : pc;

    always_comb begin
        case (src_b)
            exu_pkg::src_rs2: b_sel = rs2;
            exu_pkg::src_csr: b_sel = csr;
            default:          b_sel = imm;
        endcase
    end

    // room when empty or draining on this edge
    assign in_ready = active && !flush && (!issue.valid || issue.ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            active      <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (flush) begin
                issue.valid <= 1'b0;
            end else if (accept) begin
                issue.valid <= 1'b1;
            end else if (issue.ready) begin
                issue.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.a    <= a_sel;
            issue.b    <= b_sel;
            issue.op   <= op;
            issue.word <= word;
        end
    end

    // payload held for the execute stage until it takes it
    a_issue_stable: assert property (@(posedge clk) disable iff (reset)
        issue.valid && !issue.ready && !flush |=>
        issue.valid && $stable({issue.a, issue.b, issue.op, issue.word}));

endmodule

/* logic/seq_multiplier.sv */
`include "exu_macros.svh"

module seq_multiplier (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    abort,
    input  logic                    start,
    input  logic [`EXU_XLEN-1:0]    a,
    input  logic [`EXU_XLEN-1:0]    b,
    output logic                    done,
    output logic [`EXU_XLEN-1:0]    product
);

    localparam int XLEN  = `EXU_XLEN;
    localparam int CNT_W = `EXU_MUL_CNT_W;

    // counter value on the last iteration
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(XLEN - 1);

    exu_pkg::mul_state_e state;
    logic [CNT_W-1:0]    cnt;
    logic [XLEN-1:0]     mcand;
    logic [XLEN-1:0]     mplier;
    logic [XLEN-1:0]     acc;

    always_ff @(posedge clk) begin
        if (reset || abort) begin
            state <= exu_pkg::mul_idle;
            cnt   <= '0;
        end else begin
            case (state)
                exu_pkg::mul_idle: begin
                    if (start) begin
                        state <= exu_pkg::mul_busy;
                        cnt   <= '0;
                    end
                end
                exu_pkg::mul_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_ITER) begin
                        state <= exu_pkg::mul_done;
                    end
                end
                default: begin
                    // done lasts one cycle
                    state <= exu_pkg::mul_idle;
                end
            endcase
        end
    end

    // radix-2 datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (state == exu_pkg::mul_idle && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == exu_pkg::mul_busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign done    = (state == exu_pkg::mul_done);
    assign product = acc;

    // the execute stage never restarts a running multiply
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> state != exu_pkg::mul_busy);

endmodule

/* logic/alu_execute.sv */
`include "exu_macros.svh"

module alu_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    exu_stage_if.sink               issue,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`EXU_XLEN-1:0]    res
);

    localparam int XLEN    = `EXU_XLEN;
    localparam int SHAMT_W = `EXU_SHAMT_W;

    localparam logic [XLEN-1:0] ALL_ONES = '1;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic                 take;
    logic                 is_mul;
    logic                 mul_start;
    logic                 mul_wait;
    logic                 mul_done;
    logic [XLEN-1:0]      mul_product;
    logic [SHAMT_W-1:0]   shamt;
    logic                 div_by_zero;
    logic                 div_ovf;
    logic [XLEN-1:0]      quot_s;
    logic [XLEN-1:0]      rem_s;
    logic [XLEN-1:0]      quot_u;
    logic [XLEN-1:0]      rem_u;
    logic [XLEN-1:0]      alu_res;

    // stall on multiply or while a result waits
    assign issue.ready = !mul_wait && !(out_valid && !out_ready);
    assign take        = issue.valid && issue.ready;
    assign is_mul      = (issue.op == alu_pkg::alu_mul);
    assign mul_start   = take && is_mul;

    seq_multiplier i_mul (
        .clk     (clk),
        .reset   (reset),
        .abort   (flush),
        .start   (mul_start),
        .a       (issue.a),
        .b       (issue.b),
        .done    (mul_done),
        .product (mul_product)
    );

    assign shamt       = issue.b[SHAMT_W-1:0];
    assign div_by_zero = (issue.b == '0);
    assign div_ovf     = (issue.a == MOST_NEG) && (issue.b == ALL_ONES);

    // raw quotients, zero divisor and overflow patched below
    assign quot_s = $signed(issue.a) / $signed(issue.b);
    assign rem_s  = $signed(issue.a) % $signed(issue.b);
    assign quot_u = issue.a / issue.b;
    assign rem_u  = issue.a % issue.b;

    always_comb begin
        case (issue.op)
            alu_pkg::alu_add:      alu_res = issue.a + issue.b;
            alu_pkg::alu_sub:      alu_res = issue.a - issue.b;
            alu_pkg::alu_return_a: alu_res = issue.a;
            alu_pkg::alu_return_b: alu_res = issue.b;
            alu_pkg::alu_xor:      alu_res = issue.a ^ issue.b;
            alu_pkg::alu_or:       alu_res = issue.a | issue.b;
            alu_pkg::alu_and:      alu_res = issue.a & issue.b;
            alu_pkg::alu_sll:      alu_res = issue.a << shamt;
            alu_pkg::alu_srl:      alu_res = issue.a >> shamt;
            alu_pkg::alu_sra: begin
                // word form keeps the upper half clear
                if (issue.word) begin
                    alu_res = {32'b0, ($signed(issue.a[31:0]) >>> shamt)};
                end else begin
                    alu_res = $signed(issue.a) >>> shamt;
                end
            end
            alu_pkg::alu_slt:
                alu_res = XLEN'($signed(issue.a) < $signed(issue.b));
            alu_pkg::alu_sltu:     alu_res = XLEN'(issue.a < issue.b);
            alu_pkg::alu_eq:       alu_res = XLEN'(issue.a == issue.b);
            alu_pkg::alu_ge:
                alu_res = XLEN'($signed(issue.a) >= $signed(issue.b));
            alu_pkg::alu_geu:      alu_res = XLEN'(issue.a >= issue.b);
            alu_pkg::alu_div: begin
                if (div_by_zero) begin
                    alu_res = ALL_ONES;
                end else if (div_ovf) begin
                    alu_res = issue.a;
                end else begin
                    alu_res = quot_s;
                end
            end
            alu_pkg::alu_divu:     alu_res = div_by_zero ? ALL_ONES : quot_u;
            alu_pkg::alu_rem: begin
                if (div_by_zero) begin
                    alu_res = issue.a;
                end else if (div_ovf) begin
                    alu_res = '0;
                end else begin
                    alu_res = rem_s;
                end
            end
            alu_pkg::alu_remu:     alu_res = div_by_zero ? issue.a : rem_u;
            // mul comes back through the multiplier
            default:               alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
            mul_wait  <= 1'b0;
        end else begin
            if (mul_start) begin
                mul_wait <= 1'b1;
            end else if (mul_done) begin
                mul_wait <= 1'b0;
            end
            if ((take && !is_mul) || (mul_wait && mul_done)) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // result register, no reset on the payload
    always_ff @(posedge clk) begin
        if (mul_wait && mul_done) begin
            res <= mul_product;
        end else if (take && !is_mul) begin
            res <= alu_res;
        end
    end

    // held result survives back-pressure
    a_res_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(res));

endmodule

/* logic/exu_top.sv */
`include "exu_macros.svh"

module exu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`EXU_XLEN-1:0]    pc,
    input  logic [`EXU_XLEN-1:0]    rs1,
    input  logic [`EXU_XLEN-1:0]    rs2,
    input  logic [`EXU_XLEN-1:0]    csr,
    input  logic [`EXU_XLEN-1:0]    imm,
    input  exu_pkg::src_a_e         src_a,
    input  exu_pkg::src_b_e         src_b,
    input  logic                    word,
    input  alu_pkg::alu_op_e        op,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`EXU_XLEN-1:0]    res
);

    // one operation in flight between the stages
    exu_stage_if stage ();

    operand_select i_operand_select (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .src_a    (src_a),
        .src_b    (src_b),
        .word     (word),
        .op       (op),
        .issue    (stage.source)
    );

    alu_execute i_alu_execute (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .issue     (stage.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .res       (res)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* tb/exu_tb.sv */
`include "exu_macros.svh"

module exu_tb;

    localparam int XLEN    = `EXU_XLEN;
    localparam int PERIOD  = 10;
    localparam int N_BASIC = 114;
    localparam int N_WORD  = 27;
    localparam int N_DIV   = 8;
    localparam int N_MUL   = 10;
    localparam int N_BP    = 40;
    localparam int N_FLUSH = 12;
    localparam int N_OPS   = N_BASIC + N_WORD + N_DIV + N_MUL + N_BP + N_FLUSH;
    localparam int BP_LEN  = 256;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic                clk;
    logic                reset;
    logic                flush;
    logic                in_valid;
    logic                in_ready;
    logic                word;
    logic                out_valid;
    logic                out_ready;
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     rs1;
    logic [XLEN-1:0]     rs2;
    logic [XLEN-1:0]     csr;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     res;
    exu_pkg::src_a_e     src_a;
    exu_pkg::src_b_e     src_b;
    alu_pkg::alu_op_e    op;

    integer              seed = 32'h7ddb_a110;
    int                  errors = 0;
    int                  checked = 0;
    logic [XLEN-1:0]     exp_q[$];
    logic                bp_enable = 1'b0;
    bit                  bp_pattern[BP_LEN];
    int                  bp_idx = 0;
    logic                held = 1'b0;
    logic [XLEN-1:0]     held_res;

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(4)) i_clock (.clk(clk), .reset(reset));

    exu_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .src_a     (src_a),
        .src_b     (src_b),
        .word      (word),
        .op        (op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .res       (res)
    );

    // expected result from operand selection and riscv alu rules
    function automatic logic [XLEN-1:0] exu_ref(
        input alu_pkg::alu_op_e o,
        input exu_pkg::src_a_e  sa,
        input exu_pkg::src_b_e  sb,
        input logic             w,
        input logic [XLEN-1:0]  pc_v,
        input logic [XLEN-1:0]  rs1_v,
        input logic [XLEN-1:0]  rs2_v,
        input logic [XLEN-1:0]  csr_v,
        input logic [XLEN-1:0]  imm_v
    );
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [5:0]         sh;
        logic signed [31:0] lo;
        logic [XLEN-1:0]    r;
        a  = (sa == exu_pkg::src_rs1) ? (w ? {32'h0, rs1_v[31:0]} : rs1_v) : pc_v;
        b  = (sb == exu_pkg::src_rs2) ? rs2_v : (sb == exu_pkg::src_csr) ? csr_v : imm_v;
        sh = b[5:0];
        lo = a[31:0];
        case (o)
            alu_pkg::alu_add:      r = a + b;
            alu_pkg::alu_sub:      r = a - b;
            alu_pkg::alu_return_a: r = a;
            alu_pkg::alu_return_b: r = b;
            alu_pkg::alu_xor:      r = a ^ b;
            alu_pkg::alu_or:       r = a | b;
            alu_pkg::alu_and:      r = a & b;
            alu_pkg::alu_sll:      r = a << sh;
            alu_pkg::alu_srl:      r = a >> sh;
            alu_pkg::alu_sra: begin
                if (w) r = {32'h0, lo >>> sh};
                else r = $signed(a) >>> sh;
            end
            alu_pkg::alu_slt:      r = ($signed(a) < $signed(b)) ? 1 : 0;
            alu_pkg::alu_sltu:     r = (a < b) ? 1 : 0;
            alu_pkg::alu_eq:       r = (a == b) ? 1 : 0;
            alu_pkg::alu_ge:       r = ($signed(a) >= $signed(b)) ? 1 : 0;
            alu_pkg::alu_geu:      r = (a >= b) ? 1 : 0;
            alu_pkg::alu_mul:      r = a * b;
            alu_pkg::alu_div: begin
                if (b == '0) r = '1;
                else if (a == MOST_NEG && b == '1) r = a;
                else r = $signed(a) / $signed(b);
            end
            alu_pkg::alu_divu:     r = (b == '0) ? '1 : a / b;
            alu_pkg::alu_rem: begin
                if (b == '0) r = a;
                else if (a == MOST_NEG && b == '1) r = '0;
                else r = $signed(a) % $signed(b);
            end
            alu_pkg::alu_remu:     r = (b == '0) ? a : a % b;
            default:               r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic randomize_operands();
        pc  = rand64();
        rs1 = rand64();
        rs2 = rand64();
        csr = rand64();
        imm = rand64();
        // sometimes equal operands so compares see both outcomes
        if (($random(seed) & 7) == 0) begin
            rs1 = pc;
            rs2 = pc;
            csr = pc;
            imm = pc;
        end
    endtask

    // called just after an edge, returns just after the accepting edge
    task automatic issue_op(input alu_pkg::alu_op_e o, input exu_pkg::src_a_e sa,
                            input exu_pkg::src_b_e sb, input logic w);
        logic accepted;
        op       = o;
        src_a    = sa;
        src_b    = sb;
        word     = w;
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (in_ready) begin
                exp_q.push_back(exu_ref(o, sa, sb, w, pc, rs1, rs2, csr, imm));
                accepted = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_random_op();
        alu_pkg::alu_op_e o;
        exu_pkg::src_a_e  sa;
        exu_pkg::src_b_e  sb;
        logic             w;
        randomize_operands();
        o  = alu_pkg::alu_op_e'($unsigned($random(seed)) % 20);
        sa = exu_pkg::src_a_e'($random(seed) & 1);
        sb = exu_pkg::src_b_e'($unsigned($random(seed)) % 3);
        w  = 1'($random(seed));
        issue_op(o, sa, sb, w);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // out_ready runs of 1 to 8 cycles
    task automatic fill_ready_pattern();
        int i;
        int run;
        bit level;
        i     = 0;
        level = 1'b0;
        while (i < BP_LEN) begin
            run = 1 + ($unsigned($random(seed)) % 8);
            repeat (run) begin
                if (i < BP_LEN) bp_pattern[i] = level;
                i++;
            end
            level = !level;
        end
    endtask

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (bp_enable) begin
                out_ready = bp_pattern[bp_idx];
                bp_idx    = (bp_idx + 1) % BP_LEN;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // sampled mid-cycle, acts on the handshake of the next edge
    always @(negedge clk) begin
        if (reset) begin
            held = 1'b0;
            if (in_ready === 1'b1) begin
                errors++;
                $display("in_ready is high during reset at %0t", $time);
            end
        end else if (flush) begin
            exp_q.delete();
            held = 1'b0;
        end else begin
            if (held && !out_valid) begin
                errors++;
                $display("result dropped while out_ready was low at %0t", $time);
            end
            if (held && out_valid && res !== held_res) begin
                errors++;
                $display("[FAIL] %0t res held %h changed to %h", $time, held_res, res);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("result %h arrived with nothing outstanding at %0t", res, $time);
                end else begin
                    held_res = exp_q.pop_front();
                    checked++;
                    if (res !== held_res) begin
                        errors++;
                        $display("[FAIL] %0t res expected %h got %h", $time, held_res, res);
                    end
                end
            end
            held     = out_valid && !out_ready;
            held_res = res;
        end
    end

    initial begin
        #((N_OPS * 80 + 200) * PERIOD);
        $display("timeout, %0d results never arrived", exp_q.size());
        $display("tests failed");
        $finish;
    end

    initial begin
        alu_pkg::alu_op_e o;
        int k;
        int sa;
        int sb;
        in_valid = 1'b0;
        flush    = 1'b0;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        imm      = '0;
        src_a    = exu_pkg::src_pc;
        src_b    = exu_pkg::src_rs2;
        word     = 1'b0;
        op       = alu_pkg::alu_add;
        fill_ready_pattern();
        wait (reset === 1'b0);
        @(posedge clk);
        #1;
        if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid is not low after reset");
        end

        // every non-multiply op with every operand source
        for (k = 0; k < 20; k++) begin
            o = alu_pkg::alu_op_e'(k);
            if (o != alu_pkg::alu_mul) begin
                for (sa = 0; sa < 2; sa++) begin
                    for (sb = 0; sb < 3; sb++) begin
                        randomize_operands();
                        issue_op(o, exu_pkg::src_a_e'(sa), exu_pkg::src_b_e'(sb), 1'b0);
                    end
                end
            end
        end
        wait_drain();

        // word mode, rs1 narrowed
        for (k = 0; k < 20; k++) begin
            o = alu_pkg::alu_op_e'(k);
            if (o != alu_pkg::alu_mul) begin
                randomize_operands();
                sb = $unsigned($random(seed)) % 3;
                issue_op(o, exu_pkg::src_rs1, exu_pkg::src_b_e'(sb), 1'b1);
            end
        end
        repeat (8) begin
            randomize_operands();
            rs1[31] = 1'b1;
            issue_op(alu_pkg::alu_sra, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b1);
        end
        wait_drain();

        // zero divisor and signed overflow
        for (k = 0; k < 4; k++) begin
            o = alu_pkg::alu_op_e'(int'(alu_pkg::alu_div) + k);
            randomize_operands();
            rs2 = '0;
            issue_op(o, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b0);
            rs1 = MOST_NEG;
            rs2 = '1;
            issue_op(o, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b0);
        end
        wait_drain();

        // back-to-back multiplies, then one op right behind a multiply
        repeat (6) begin
            randomize_operands();
            issue_op(alu_pkg::alu_mul, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b0);
        end
        rs1 = '1;
        rs2 = '1;
        issue_op(alu_pkg::alu_mul, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b0);
        rs1 = MOST_NEG;
        issue_op(alu_pkg::alu_mul, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b0);
        randomize_operands();
        issue_op(alu_pkg::alu_mul, exu_pkg::src_pc, exu_pkg::src_imm, 1'b0);
        issue_op(alu_pkg::alu_add, exu_pkg::src_rs1, exu_pkg::src_csr, 1'b0);
        wait_drain();

        bp_enable = 1'b1;
        repeat (N_BP) send_random_op();
        bp_enable = 1'b0;
        wait_drain();

        // flush with a multiply running and a second op waiting
        randomize_operands();
        issue_op(alu_pkg::alu_mul, exu_pkg::src_rs1, exu_pkg::src_rs2, 1'b0);
        issue_op(alu_pkg::alu_sub, exu_pkg::src_rs1, exu_pkg::src_imm, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        pulse_flush();
        repeat (70) @(posedge clk);
        #1;
        repeat (N_FLUSH - 2) send_random_op();
        wait_drain();

        $display("results checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/alu_pkg.sv
logic/exu_pkg.sv
logic/exu_stage_if.sv
logic/operand_select.sv
logic/seq_multiplier.sv
logic/alu_execute.sv
logic/exu_top.sv
tb/tb_clock.sv
tb/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - logic
    files:
      - logic/alu_pkg.sv
      - logic/exu_pkg.sv
      - logic/exu_stage_if.sv
      - logic/operand_select.sv
      - logic/seq_multiplier.sv
      - logic/alu_execute.sv
      - logic/exu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_clock.sv
      - tb/exu_tb.sv
